// File: include/imuldiv_macros.svh
// width and iteration constants for the multiply/divide unit
// shared by the package and every RTL module

`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

// operand width in bits
`define IMULDIV_XLEN 32

// one shift step per operand bit
`define IMULDIV_ITERS 32

// down-counter width, counts ITERS-1 to zero
`define IMULDIV_CNT_W 5

`endif

// File: hw/imuldiv_pkg.sv
// opcode and unit state enums
// request, response and counter types for the multiply/divide unit

`include "imuldiv_macros.svh"

package imuldiv_pkg;

  // ----------------------------------------
  // opcodes
  // ----------------------------------------
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } imuldiv_op_e;

  // ----------------------------------------
  // request and response payloads
  // ----------------------------------------
  typedef struct packed {
    imuldiv_op_e               op;
    logic [`IMULDIV_XLEN-1:0]  a;
    logic [`IMULDIV_XLEN-1:0]  b;
  } imuldiv_req_t;

  // hi/lo halves of the product, or remainder/quotient for division
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0]  hi;
    logic [`IMULDIV_XLEN-1:0]  lo;
  } imuldiv_resp_t;

  // ----------------------------------------
  // control
  // ----------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imuldiv_state_e;

  // iteration down-counter
  typedef logic [`IMULDIV_CNT_W-1:0] imuldiv_cnt_t;

endpackage

// File: hw/imuldiv_mul_iterative.sv
// iterative signed multiplier
// control FSM plus shift-add datapath on operand magnitudes

`timescale 1ns/1ps
`include "imuldiv_macros.svh"

module imuldiv_mul_iterative (
  input  logic                        clk,
  input  logic                        reset,

  input  logic [`IMULDIV_XLEN-1:0]    req_a,
  input  logic [`IMULDIV_XLEN-1:0]    req_b,
  input  logic                        req_val,
  output logic                        req_rdy,

  output imuldiv_pkg::imuldiv_resp_t  resp,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_pkg::*;

  // ----------------------------------------
  // control state
  // ----------------------------------------
  imuldiv_state_e state;
  imuldiv_state_e state_next;
  imuldiv_cnt_t   count;

  // datapath registers
  logic                        sign_a;
  logic                        sign_b;
  logic [2*`IMULDIV_XLEN-1:0]  a_reg;
  logic [`IMULDIV_XLEN-1:0]    b_reg;
  logic [2*`IMULDIV_XLEN-1:0]  acc;

  // operand magnitudes, taken straight from the request
  logic [`IMULDIV_XLEN-1:0]    a_mag;
  logic [`IMULDIV_XLEN-1:0]    b_mag;
  logic [2*`IMULDIV_XLEN-1:0]  product;

  logic accept;
  logic xfer;

  assign accept = req_val & req_rdy;
  assign xfer   = resp_val & resp_rdy;

  // handshake outputs come straight from the state
  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // next state
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (accept) state_next = ST_CALC;
      // last step happens while count is zero
      ST_CALC: if (count == '0) state_next = ST_DONE;
      ST_DONE: if (xfer) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        count <= imuldiv_cnt_t'(`IMULDIV_ITERS - 1);
      end else if (state == ST_CALC) begin
        count <= count - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // shift-add datapath
  // ----------------------------------------
  assign a_mag = req_a[`IMULDIV_XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[`IMULDIV_XLEN-1] ? -req_b : req_b;

  always_ff @(posedge clk) begin
    if (accept) begin
      // keep signs for the final fixup
      sign_a <= req_a[`IMULDIV_XLEN-1];
      sign_b <= req_b[`IMULDIV_XLEN-1];
      a_reg  <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      b_reg  <= b_mag;
      acc    <= '0;
    end else if (state == ST_CALC) begin
      // add shifted multiplicand when current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // negative product when exactly one operand was negative
  assign product = (sign_a ^ sign_b) ? -acc : acc;

  // held stable in ST_DONE since nothing updates there
  assign resp = imuldiv_resp_t'(product);

endmodule

// File: hw/imuldiv_div_iterative.sv
// iterative restoring divider, signed and unsigned
// control FSM plus shift-subtract datapath with sign fixup at the end

`timescale 1ns/1ps
`include "imuldiv_macros.svh"

module imuldiv_div_iterative (
  input  logic                        clk,
  input  logic                        reset,

  input  imuldiv_pkg::imuldiv_req_t   req,
  input  logic                        req_val,
  output logic                        req_rdy,

  output imuldiv_pkg::imuldiv_resp_t  resp,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_pkg::*;

  // ----------------------------------------
  // control state
  // ----------------------------------------
  imuldiv_state_e state;
  imuldiv_state_e state_next;
  imuldiv_cnt_t   count;

  // captured at accept
  logic                        is_signed;
  logic                        sign_a;
  logic                        sign_b;

  // quotient shifts in from the bottom as dividend bits leave the top
  logic [`IMULDIV_XLEN-1:0]    quot_reg;
  logic [`IMULDIV_XLEN-1:0]    rem_reg;
  logic [`IMULDIV_XLEN-1:0]    divisor;

  logic                        req_signed;
  logic [`IMULDIV_XLEN-1:0]    a_mag;
  logic [`IMULDIV_XLEN-1:0]    b_mag;

  // one extra bit for the shifted remainder, one more for the borrow
  logic [`IMULDIV_XLEN:0]      rem_shift;
  logic [`IMULDIV_XLEN+1:0]    diff;
  logic                        diff_ok;

  logic                        neg_quot;
  logic                        neg_rem;

  logic accept;
  logic xfer;

  assign accept = req_val & req_rdy;
  assign xfer   = resp_val & resp_rdy;

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (accept) state_next = ST_CALC;
      ST_CALC: if (count == '0) state_next = ST_DONE;
      ST_DONE: if (xfer) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        count <= imuldiv_cnt_t'(`IMULDIV_ITERS - 1);
      end else if (state == ST_CALC) begin
        count <= count - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // operand setup
  // ----------------------------------------
  assign req_signed = (req.op == OP_DIV);

  // DIVU passes the raw values through
  assign a_mag = (req_signed && req.a[`IMULDIV_XLEN-1]) ? -req.a : req.a;
  assign b_mag = (req_signed && req.b[`IMULDIV_XLEN-1]) ? -req.b : req.b;

  // trial subtraction for this step
  assign rem_shift = {rem_reg, quot_reg[`IMULDIV_XLEN-1]};
  assign diff      = {1'b0, rem_shift} - {2'b00, divisor};
  assign diff_ok   = ~diff[`IMULDIV_XLEN+1];

  always_ff @(posedge clk) begin
    if (accept) begin
      is_signed <= req_signed;
      sign_a    <= req.a[`IMULDIV_XLEN-1];
      sign_b    <= req.b[`IMULDIV_XLEN-1];
      quot_reg  <= a_mag;
      divisor   <= b_mag;
      rem_reg   <= '0;
    end else if (state == ST_CALC) begin
      // keep the difference only when it did not borrow
      rem_reg  <= diff_ok ? diff[`IMULDIV_XLEN-1:0] : rem_shift[`IMULDIV_XLEN-1:0];
      quot_reg <= {quot_reg[`IMULDIV_XLEN-2:0], diff_ok};
    end
  end

  // ----------------------------------------
  // sign fixup
  // ----------------------------------------
  // a zero divisor already yields an all-ones quotient, leave it unsigned
  assign neg_quot = is_signed & (sign_a ^ sign_b) & (divisor != '0);
  // remainder follows the dividend
  assign neg_rem  = is_signed & sign_a;

  always_comb begin
    resp.lo = neg_quot ? -quot_reg : quot_reg;
    resp.hi = neg_rem ? -rem_reg : rem_reg;
  end

endmodule

// File: hw/imuldiv_top.sv
// multiply/divide unit top level
// opcode steering to the two iterative units and response merge

`timescale 1ns/1ps

module imuldiv_top (
  input  logic                        clk,
  input  logic                        reset,

  input  imuldiv_pkg::imuldiv_req_t   req,
  input  logic                        req_val,
  output logic                        req_rdy,

  output imuldiv_pkg::imuldiv_resp_t  resp,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_pkg::*;

  // per-unit handshakes
  logic          mul_req_val;
  logic          mul_req_rdy;
  imuldiv_resp_t mul_resp;
  logic          mul_resp_val;

  logic          div_req_val;
  logic          div_req_rdy;
  imuldiv_resp_t div_resp;
  logic          div_resp_val;

  // ----------------------------------------
  // request steering
  // ----------------------------------------
  assign mul_req_val = req_val & (req.op == OP_MUL);
  assign div_req_val = req_val & ((req.op == OP_DIV) | (req.op == OP_DIVU));

  // both idle before anything new goes in, keeps one op in flight
  assign req_rdy = mul_req_rdy & div_req_rdy;

  imuldiv_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req.a),
    .req_b    (req.b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy)
  );

  // divider decodes signedness from the op field itself
  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy)
  );

  // ----------------------------------------
  // response merge
  // ----------------------------------------
  // at most one unit is valid at a time
  assign resp_val = mul_resp_val | div_resp_val;
  assign resp     = div_resp_val ? div_resp : mul_resp;

endmodule

// File: verification/imuldiv_tb.sv
// testbench for the multiply/divide unit
// file-driven vectors, random response back-pressure, latency and hold checks, watchdog

`timescale 1ns/1ps
`include "imuldiv_macros.svh"

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int CLK_PERIOD = 40;
  // first cycle after the accept edge in which resp_val is high
  localparam int RESP_CYCLE = `IMULDIV_ITERS + 1;
  localparam int CYCLES_PER_VEC = 80;
  localparam longint MARGIN_NS = 20 * CLK_PERIOD;
  localparam string INPUT_FILE = "verification/imuldiv_input.txt";

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;

  // vectors from the data file
  logic [1:0]               vec_op[$];
  logic [`IMULDIV_XLEN-1:0] vec_a[$];
  logic [`IMULDIV_XLEN-1:0] vec_b[$];
  logic [`IMULDIV_XLEN-1:0] exp_hi[$];
  logic [`IMULDIV_XLEN-1:0] exp_lo[$];

  int error_count = 0;
  int check_count = 0;
  int transfers = 0;
  bit loaded = 1'b0;

  imuldiv_top u_imuldiv_top (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // every response handshake seen on the DUT port
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      transfers++;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("error @ %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  // consumer ready about 70% of the cycles
  function automatic logic pick_ready();
    return ($urandom % 100) < 70;
  endfunction

  task automatic print_summary();
    $display("summary: %0d vectors, %0d transfers, %0d checks, %0d errors",
             vec_op.size(), transfers, check_count, error_count);
  endtask

  task automatic load_vectors();
    int          fd;
    int          line_no;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] hi;
    logic [31:0] lo;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", INPUT_FILE);
      error_count++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      // skip comment and blank lines
      if (n == 0 || line.len() < 2 || line[0] == "/") continue;
      n = $sscanf(line, "%h %h %h %h %h", op, a, b, hi, lo);
      if (n != 5 || op > 32'd2) begin
        $display("data line %0d is incomplete or has an unknown opcode", line_no);
        error_count++;
      end else begin
        vec_op.push_back(op[1:0]);
        vec_a.push_back(a);
        vec_b.push_back(b);
        exp_hi.push_back(hi);
        exp_lo.push_back(lo);
      end
    end
    $fclose(fd);
    if (vec_op.size() == 0) begin
      $display("no test vectors were found in %s", INPUT_FILE);
      error_count++;
    end
  endtask

  // ----------------------------------------
  // one request/response exchange
  // ----------------------------------------
  // entered and left on a falling edge, outputs depend on unit state only
  task automatic run_vector(input int idx);
    imuldiv_resp_t expected;
    imuldiv_resp_t held;
    int            cycle;
    logic          seen;
    logic          done;
    expected.hi = exp_hi[idx];
    expected.lo = exp_lo[idx];
    held        = '0;
    req.op      = imuldiv_op_e'(vec_op[idx]);
    req.a       = vec_a[idx];
    req.b       = vec_b[idx];
    req_val     = 1'b1;
    resp_rdy    = pick_ready();
    // hold the request until the unit is idle
    while (!req_rdy) begin
      @(negedge clk);
      resp_rdy = pick_ready();
    end
    @(negedge clk);
    // the accept edge has passed
    req_val = 1'b0;
    req     = '0;
    cycle   = 1;
    seen    = 1'b0;
    done    = 1'b0;
    while (!done) begin
      check_value($sformatf("vector %0d req_rdy while busy", idx), req_rdy, 1'b0);
      if (resp_val && !seen) begin
        seen = 1'b1;
        check_value($sformatf("vector %0d response latency", idx), cycle, RESP_CYCLE);
        check_value($sformatf("vector %0d result (op %0d)", idx, vec_op[idx]), resp, expected);
        held = resp;
      end else if (seen) begin
        // still waiting on the consumer
        check_value($sformatf("vector %0d resp_val under back-pressure", idx), resp_val, 1'b1);
        check_value($sformatf("vector %0d resp under back-pressure", idx), resp, held);
      end
      resp_rdy = pick_ready();
      done     = seen && resp_val && resp_rdy;
      @(negedge clk);
      cycle++;
    end
    // unit is back in idle one cycle after the transfer
    check_value($sformatf("vector %0d resp_val after transfer", idx), resp_val, 1'b0);
    check_value($sformatf("vector %0d req_rdy after transfer", idx), req_rdy, 1'b1);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h1a40_b706));
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // idle right after reset
    check_value("resp_val after reset", resp_val, 1'b0);
    check_value("req_rdy after reset", req_rdy, 1'b1);
    for (int i = 0; i < vec_op.size(); i++) begin
      run_vector(i);
    end
    // one handshake per vector, none extra
    check_value("responses transferred", transfers, vec_op.size());
    print_summary();
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, sized from the vector count
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(vec_op.size()) * CYCLES_PER_VEC * CLK_PERIOD + MARGIN_NS;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verification/imuldiv_input.txt
// columns: opcode (0 mul, 1 div, 2 divu), a, b, expected hi, expected lo, all hex
// hi is the upper product half or the remainder, lo the lower half or the quotient
0 00000003 00000005 00000000 0000000f
0 00000000 12345678 00000000 00000000
0 ffffffff ffffffff 00000000 00000001
0 ffffffff 00000001 ffffffff ffffffff
0 00000007 fffffffd ffffffff ffffffeb
0 fffffff8 fffffff8 00000000 00000040
0 7fffffff 7fffffff 3fffffff 00000001
0 80000000 80000000 40000000 00000000
0 80000000 00000001 ffffffff 80000000
0 80000000 ffffffff 00000000 80000000
0 80000000 7fffffff c0000000 80000000
0 00010000 00010000 00000001 00000000
0 12345678 00000000 00000000 00000000
0 000003e8 fffffc18 ffffffff fff0bdc0
0 0000ffff 0000ffff 00000000 fffe0001
2 00000064 00000007 00000002 0000000e
2 ffffffff 00000002 00000001 7fffffff
2 80000000 ffffffff 80000000 00000000
2 ffffffff ffffffff 00000000 00000001
2 00000005 00000000 00000005 ffffffff
2 00000000 00000000 00000000 ffffffff
2 12345678 00000010 00000008 01234567
2 00000007 00000064 00000007 00000000
1 00000064 00000007 00000002 0000000e
1 ffffff9c 00000007 fffffffe fffffff2
1 00000064 fffffff9 00000002 fffffff2
1 ffffff9c fffffff9 fffffffe 0000000e
1 00000007 00000002 00000001 00000003
1 fffffff9 00000002 ffffffff fffffffd
1 00000005 00000000 00000005 ffffffff
1 fffffffb 00000000 fffffffb ffffffff
1 80000000 ffffffff 00000000 80000000
1 80000000 00000001 00000000 80000000
1 80000000 00000002 00000000 c0000000
1 00000000 ffffffff 00000000 00000000
1 7fffffff ffffffff 00000000 80000001
1 ffffffff 00000002 ffffffff 00000000
1 80000000 7fffffff ffffffff ffffffff

// File: build.f
+incdir+include
hw/imuldiv_pkg.sv
hw/imuldiv_mul_iterative.sv
hw/imuldiv_div_iterative.sv
hw/imuldiv_top.sv
verification/imuldiv_tb.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit
# variables below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully
BIN       := $(BUILD_DIR)/V$(TOP)

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED, no result in $(LOG)"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
